/* line_evaluator.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module line_evaluator (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  hsync,
    input  logic [`PPU_VCOUNT_W-1:0]              vcount,
    input  logic [`PPU_Y_W-1:0]                   eval_y,
    input  logic                                  list_ack,
    output ppu_pkg::sprite_idx_t                  eval_index,
    output logic                                  list_req,
    output ppu_pkg::sprite_idx_t [`PPU_SLOTS-1:0] slot_sprite,
    output logic [$clog2(`PPU_SLOTS):0]           slot_count
);
    import ppu_pkg::*;

    // One extra bit so that y + height never wraps
    localparam int CMP_W = `PPU_Y_W + 1;

    eval_state_t         state;
    sprite_idx_t         scan_idx;
    logic [CMP_W-1:0]    line_wide;
    logic [CMP_W-1:0]    y_start;
    logic [CMP_W-1:0]    y_end;
    logic                covers;
    logic                room;

    assign eval_index = scan_idx;

    always_comb begin
        line_wide = CMP_W'(vcount);
        y_start   = CMP_W'(eval_y);
        y_end     = y_start + CMP_W'(`PPU_SPRITE_HEIGHT);
        covers    = (line_wide >= y_start) && (line_wide < y_end);
    end

    // Later matches are dropped once all slots are taken
    assign room = (slot_count < `PPU_SLOTS);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= EVAL_IDLE;
            scan_idx    <= '0;
            list_req    <= 1'b0;
            slot_count  <= '0;
            slot_sprite <= '0;
        end else if (!hsync) begin
            // Line over or aborted
            state      <= EVAL_IDLE;
            scan_idx   <= '0;
            list_req   <= 1'b0;
            slot_count <= '0;
        end else begin
            case (state)
                // First sprite is tested in the cycle that sees hsync
                EVAL_IDLE, EVAL_SCAN: begin
                    if (covers && room) begin
                        slot_sprite[slot_idx_t'(slot_count)] <= scan_idx;
                        slot_count <= slot_count + 1'b1;
                    end
                    scan_idx <= scan_idx + 1'b1;
                    if (scan_idx == sprite_idx_t'(`PPU_NUM_SPRITES - 1)) begin
                        state    <= EVAL_OFFER;
                        list_req <= 1'b1;
                    end else begin
                        state <= EVAL_SCAN;
                    end
                end
                EVAL_OFFER: begin
                    if (list_ack) begin
                        list_req <= 1'b0;
                        state    <= EVAL_RELEASE;
                    end
                end
                EVAL_RELEASE: begin
                    // Hold here until hsync falls
                    state <= EVAL_RELEASE;
                end
                default: begin
                    state <= EVAL_IDLE;
                end
            endcase
        end
    end

endmodule

/* oam_loader.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module oam_loader (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      vblank,
    input  logic [`PPU_WORD_W-1:0]    oam_rdata,
    output logic [`PPU_OAM_AW-1:0]    oam_addr,
    output logic                      y_we,
    output logic                      attr_we,
    output ppu_pkg::sprite_idx_t      wr_index,
    output logic [`PPU_Y_W-1:0]       wr_y,
    output ppu_pkg::tile_id_t         wr_tile,
    output ppu_pkg::flip_t            wr_flip
);
    import ppu_pkg::*;

    localparam int LAST_ADDR = 2 * `PPU_NUM_SPRITES - 1;

    oam_state_t               state;
    logic [`PPU_OAM_AW-1:0]   rd_addr;
    // Address of the word arriving on oam_rdata this cycle
    logic [`PPU_OAM_AW-1:0]   pend_addr;
    logic                     pend_valid;

    // Address goes straight out, the RAM registers it on the next edge
    assign oam_addr = rd_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= OAM_IDLE;
            rd_addr    <= '0;
            pend_addr  <= '0;
            pend_valid <= 1'b0;
        end else if (!vblank) begin
            // Outside vblank, rearm for the next frame
            state      <= OAM_IDLE;
            rd_addr    <= '0;
            pend_valid <= 1'b0;
        end else begin
            case (state)
                OAM_IDLE, OAM_READ: begin
                    pend_addr  <= rd_addr;
                    pend_valid <= 1'b1;
                    rd_addr    <= rd_addr + 1'b1;
                    if (rd_addr == `PPU_OAM_AW'(LAST_ADDR)) begin
                        state <= OAM_DONE;
                    end else begin
                        state <= OAM_READ;
                    end
                end
                OAM_DONE: begin
                    // Last word lands during the first DONE cycle
                    pend_valid <= 1'b0;
                end
                default: begin
                    state <= OAM_IDLE;
                end
            endcase
        end
    end

    // Odd addresses hold the coordinate word, even ones the attribute word
    assign y_we     = pend_valid &  pend_addr[0];
    assign attr_we  = pend_valid & ~pend_addr[0];
    assign wr_index = pend_addr[`PPU_OAM_AW-1:1];

    // y sits in the upper half of the coordinate word
    assign wr_y     = oam_rdata[`PPU_WORD_W-1 -: `PPU_Y_W];
    assign wr_tile  = oam_rdata[6:0];
    assign wr_flip  = oam_rdata[31:30];

endmodule

/* ppu_config.svh */
`ifndef PPU_CONFIG_SVH
`define PPU_CONFIG_SVH

// Sprite population and per-line limits
`define PPU_NUM_SPRITES   128
`define PPU_SLOTS         8
`define PPU_SPRITE_HEIGHT 16

// OAM and sprite graphics words share one width
`define PPU_WORD_W        32

// Memory address widths
`define PPU_OAM_AW        8
`define PPU_GFX_AW        11

// Raster and sprite position widths
`define PPU_VCOUNT_W      10
`define PPU_Y_W           16

`endif

/* ppu_pkg.sv */
`include "ppu_config.svh"

package ppu_pkg;

    // Index into the 128-entry sprite attribute table
    typedef logic [$clog2(`PPU_NUM_SPRITES)-1:0] sprite_idx_t;

    // Index into the per-line slot list
    typedef logic [$clog2(`PPU_SLOTS)-1:0] slot_idx_t;

    typedef logic [6:0] tile_id_t;

    // Bit 1 is vertical flip, bit 0 is horizontal flip
    typedef logic [1:0] flip_t;

    typedef enum logic [1:0] {
        OAM_IDLE,
        OAM_READ,
        OAM_DONE
    } oam_state_t;

    typedef enum logic [1:0] {
        EVAL_IDLE,
        EVAL_SCAN,
        EVAL_OFFER,
        EVAL_RELEASE
    } eval_state_t;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_LOAD,
        FETCH_ACK
    } fetch_state_t;

endpackage

/* ppu_sprite_top.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module ppu_sprite_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   vblank,
    input  logic                                   hsync,
    input  logic [`PPU_VCOUNT_W-1:0]               vcount,
    input  logic [`PPU_WORD_W-1:0]                 oam_rdata,
    input  logic [`PPU_WORD_W-1:0]                 gfx_rdata,
    output logic [`PPU_OAM_AW-1:0]                 oam_addr,
    output logic [`PPU_GFX_AW-1:0]                 gfx_addr,
    output logic                                   shift_load_sprite,
    output logic [`PPU_SLOTS-1:0][`PPU_WORD_W-1:0] shift_load_data
);
    import ppu_pkg::*;

    // OAM loader to attribute table
    logic                y_we;
    logic                attr_we;
    sprite_idx_t         wr_index;
    logic [`PPU_Y_W-1:0] wr_y;
    tile_id_t            wr_tile;
    flip_t               wr_flip;

    // Table read ports
    sprite_idx_t         eval_index;
    sprite_idx_t         fetch_index;
    logic [`PPU_Y_W-1:0] eval_y;
    logic [`PPU_Y_W-1:0] fetch_y;
    tile_id_t            fetch_tile;
    flip_t               fetch_flip;

    // Slot list handshake
    logic                               list_req;
    logic                               list_ack;
    sprite_idx_t [`PPU_SLOTS-1:0]       slot_sprite;
    logic [$clog2(`PPU_SLOTS):0]        slot_count;

    oam_loader i_oam_loader (
        .clk       (clk),
        .reset     (reset),
        .vblank    (vblank),
        .oam_rdata (oam_rdata),
        .oam_addr  (oam_addr),
        .y_we      (y_we),
        .attr_we   (attr_we),
        .wr_index  (wr_index),
        .wr_y      (wr_y),
        .wr_tile   (wr_tile),
        .wr_flip   (wr_flip)
    );

    sprite_attr_table i_sprite_attr_table (
        .clk         (clk),
        .reset       (reset),
        .y_we        (y_we),
        .attr_we     (attr_we),
        .wr_index    (wr_index),
        .wr_y        (wr_y),
        .wr_tile     (wr_tile),
        .wr_flip     (wr_flip),
        .eval_index  (eval_index),
        .fetch_index (fetch_index),
        .eval_y      (eval_y),
        .fetch_y     (fetch_y),
        .fetch_tile  (fetch_tile),
        .fetch_flip  (fetch_flip)
    );

    line_evaluator i_line_evaluator (
        .clk         (clk),
        .reset       (reset),
        .hsync       (hsync),
        .vcount      (vcount),
        .eval_y      (eval_y),
        .list_ack    (list_ack),
        .eval_index  (eval_index),
        .list_req    (list_req),
        .slot_sprite (slot_sprite),
        .slot_count  (slot_count)
    );

    sprite_fetcher i_sprite_fetcher (
        .clk               (clk),
        .reset             (reset),
        .hsync             (hsync),
        .vcount            (vcount),
        .list_req          (list_req),
        .slot_sprite       (slot_sprite),
        .slot_count        (slot_count),
        .fetch_y           (fetch_y),
        .fetch_tile        (fetch_tile),
        .fetch_flip        (fetch_flip),
        .gfx_rdata         (gfx_rdata),
        .fetch_index       (fetch_index),
        .list_ack          (list_ack),
        .gfx_addr          (gfx_addr),
        .shift_load_sprite (shift_load_sprite),
        .shift_load_data   (shift_load_data)
    );

endmodule

/* sprite_attr_table.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module sprite_attr_table (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      y_we,
    input  logic                      attr_we,
    input  ppu_pkg::sprite_idx_t      wr_index,
    input  logic [`PPU_Y_W-1:0]       wr_y,
    input  ppu_pkg::tile_id_t         wr_tile,
    input  ppu_pkg::flip_t            wr_flip,
    input  ppu_pkg::sprite_idx_t      eval_index,
    input  ppu_pkg::sprite_idx_t      fetch_index,
    output logic [`PPU_Y_W-1:0]       eval_y,
    output logic [`PPU_Y_W-1:0]       fetch_y,
    output ppu_pkg::tile_id_t         fetch_tile,
    output ppu_pkg::flip_t            fetch_flip
);
    import ppu_pkg::*;

    logic [`PPU_Y_W-1:0] y_mem    [`PPU_NUM_SPRITES];
    tile_id_t            tile_mem [`PPU_NUM_SPRITES];
    flip_t               flip_mem [`PPU_NUM_SPRITES];

    // Coordinate and attribute words arrive on separate cycles
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
                y_mem[i]    <= '0;
                tile_mem[i] <= '0;
                flip_mem[i] <= '0;
            end
        end else begin
            if (y_we) begin
                y_mem[wr_index] <= wr_y;
            end
            if (attr_we) begin
                tile_mem[wr_index] <= wr_tile;
                flip_mem[wr_index] <= wr_flip;
            end
        end
    end

    // Scan port, only y is needed for the coverage test
    assign eval_y = y_mem[eval_index];

    // Fetch port
    assign fetch_y    = y_mem[fetch_index];
    assign fetch_tile = tile_mem[fetch_index];
    assign fetch_flip = flip_mem[fetch_index];

endmodule

/* sprite_fetcher.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module sprite_fetcher (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  hsync,
    input  logic [`PPU_VCOUNT_W-1:0]              vcount,
    input  logic                                  list_req,
    input  ppu_pkg::sprite_idx_t [`PPU_SLOTS-1:0] slot_sprite,
    input  logic [$clog2(`PPU_SLOTS):0]           slot_count,
    input  logic [`PPU_Y_W-1:0]                   fetch_y,
    input  ppu_pkg::tile_id_t                     fetch_tile,
    input  ppu_pkg::flip_t                        fetch_flip,
    input  logic [`PPU_WORD_W-1:0]                gfx_rdata,
    output ppu_pkg::sprite_idx_t                  fetch_index,
    output logic                                  list_ack,
    output logic [`PPU_GFX_AW-1:0]                gfx_addr,
    output logic                                  shift_load_sprite,
    output logic [`PPU_SLOTS-1:0][`PPU_WORD_W-1:0] shift_load_data
);
    import ppu_pkg::*;

    localparam int ROW_W = $clog2(`PPU_SPRITE_HEIGHT);

    fetch_state_t                        state;
    // Steps 0..7 issue addresses, steps 1..8 capture the word one behind
    logic [$clog2(`PPU_SLOTS):0]         step;
    logic                                issuing;
    logic [ROW_W-1:0]                    row_off;
    logic [ROW_W-1:0]                    row_sel;
    logic [`PPU_WORD_W-1:0]              word_rev;
    logic [`PPU_WORD_W-1:0]              captured;
    // Flip and valid of the slot whose word is coming back
    logic                                hflip_q;
    logic                                used_q;
    logic [`PPU_SLOTS-1:0][`PPU_WORD_W-1:0] slot_buf;

    assign issuing     = (state == FETCH_ADDR) && (step < `PPU_SLOTS);
    assign fetch_index = slot_sprite[slot_idx_t'(step)];

    always_comb begin
        // Row within the sprite, the evaluator already bounded it to 0..15
        row_off = ROW_W'(`PPU_Y_W'(vcount) - fetch_y);
        if (fetch_flip[1]) begin
            row_sel = ROW_W'(`PPU_SPRITE_HEIGHT - 1) - row_off;
        end else begin
            row_sel = row_off;
        end
        gfx_addr = issuing ? `PPU_GFX_AW'({fetch_tile, row_sel}) : '0;

        for (int i = 0; i < `PPU_WORD_W; i++) begin
            word_rev[i] = gfx_rdata[`PPU_WORD_W-1-i];
        end

        // Empty slots load as transparent
        if (!used_q) begin
            captured = '0;
        end else if (hflip_q) begin
            captured = word_rev;
        end else begin
            captured = gfx_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH_ADDR && step != '0) begin
            slot_buf[slot_idx_t'(step - 1'b1)] <= captured;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= FETCH_IDLE;
            step              <= '0;
            hflip_q           <= 1'b0;
            used_q            <= 1'b0;
            list_ack          <= 1'b0;
            shift_load_sprite <= 1'b0;
            shift_load_data   <= '0;
        end else begin
            shift_load_sprite <= 1'b0;
            if (!hsync) begin
                state    <= FETCH_IDLE;
                step     <= '0;
                list_ack <= 1'b0;
            end else begin
                case (state)
                    FETCH_IDLE: begin
                        if (list_req) begin
                            state <= FETCH_ADDR;
                            step  <= '0;
                        end
                    end
                    FETCH_ADDR: begin
                        hflip_q <= fetch_flip[0];
                        used_q  <= (step < slot_count);
                        if (step == `PPU_SLOTS) begin
                            state <= FETCH_LOAD;
                        end else begin
                            step <= step + 1'b1;
                        end
                    end
                    FETCH_LOAD: begin
                        shift_load_sprite <= 1'b1;
                        shift_load_data   <= slot_buf;
                        list_ack          <= 1'b1;
                        state             <= FETCH_ACK;
                    end
                    FETCH_ACK: begin
                        // Finish the four-phase handshake
                        if (!list_req) begin
                            list_ack <= 1'b0;
                            state    <= FETCH_IDLE;
                        end
                    end
                    default: begin
                        state <= FETCH_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

/* tb.f */
+incdir+.
ppu_pkg.sv
oam_loader.sv
sprite_attr_table.sv
line_evaluator.sv
sprite_fetcher.sv
ppu_sprite_top.sv
tb_mem_models.sv
tb_ppu_sprite.sv

/* tb_mem_models.sv */
`timescale 1ns/1ps

// Synchronous read memory with data valid one clock after the address.
// It is used for both the OAM and the sprite graphics RAM.
module sync_ram_model #(
    parameter int AW = 8,
    parameter int DW = 32
) (
    input  logic          clk,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] rdata
);
    // Loaded by the testbench before reset is released
    logic [DW-1:0] mem [2**AW];

    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

/* tb_ppu_sprite.sv */
`timescale 1ns/1ps
`include "ppu_config.svh"

module tb_ppu_sprite;

    localparam int CLK_NS          = 4;
    localparam int RESET_CYCLES    = 5;
    localparam int IDLE_CYCLES     = 20;
    localparam int VBLANK_CYCLES   = 300;
    localparam int HSYNC_CYCLES    = 160;
    localparam int LINE_CYCLES     = 170;
    localparam int LOAD_DELAY      = 139;
    localparam int NUM_LINES       = 11;
    localparam logic [31:0] SEED   = 32'h5f;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + IDLE_CYCLES + VBLANK_CYCLES
                                     + NUM_LINES * LINE_CYCLES + 200;

    // Listed sprites as index, y, tile and flip (bit 1 vertical, bit 0 horizontal)
    int sprite_tab [4][4] = '{
        '{3,  20,  5,  0},
        '{10, 60,  9,  2},
        '{12, 100, 17, 1},
        '{15, 130, 33, 3}
    };

    // Line table with expected words filled in by the reference model
    string line_name [NUM_LINES] = '{"no_sprite", "plain_top", "plain_mid", "plain_bottom",
        "above_edge", "below_edge", "vflip_first", "vflip_last", "hflip", "both_flips",
        "eleven_sprites"};
    int line_v [NUM_LINES] = '{500, 20, 27, 35, 19, 36, 60, 75, 105, 140, 300};
    logic [`PPU_WORD_W-1:0] exp_words [NUM_LINES][`PPU_SLOTS];

    logic                                   clk;
    logic                                   reset;
    logic                                   vblank;
    logic                                   hsync;
    logic [`PPU_VCOUNT_W-1:0]               vcount;
    logic [`PPU_WORD_W-1:0]                 oam_rdata;
    logic [`PPU_WORD_W-1:0]                 gfx_rdata;
    logic [`PPU_OAM_AW-1:0]                 oam_addr;
    logic [`PPU_GFX_AW-1:0]                 gfx_addr;
    logic                                   shift_load_sprite;
    logic [`PPU_SLOTS-1:0][`PPU_WORD_W-1:0] shift_load_data;

    int                     spr_y    [`PPU_NUM_SPRITES];
    int                     spr_tile [`PPU_NUM_SPRITES];
    int                     spr_flip [`PPU_NUM_SPRITES];
    logic [`PPU_WORD_W-1:0] gfx_img  [2**`PPU_GFX_AW];
    int                     errors;

    ppu_sprite_top i_dut (
        .clk               (clk),
        .reset             (reset),
        .vblank            (vblank),
        .hsync             (hsync),
        .vcount            (vcount),
        .oam_rdata         (oam_rdata),
        .gfx_rdata         (gfx_rdata),
        .oam_addr          (oam_addr),
        .gfx_addr          (gfx_addr),
        .shift_load_sprite (shift_load_sprite),
        .shift_load_data   (shift_load_data)
    );

    sync_ram_model #(.AW(`PPU_OAM_AW), .DW(`PPU_WORD_W)) i_oam (
        .clk   (clk),
        .addr  (oam_addr),
        .rdata (oam_rdata)
    );

    sync_ram_model #(.AW(`PPU_GFX_AW), .DW(`PPU_WORD_W)) i_gfx (
        .clk   (clk),
        .addr  (gfx_addr),
        .rdata (gfx_rdata)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] reverse_word(input logic [31:0] w);
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            r[i] = w[31-i];
        end
        return r;
    endfunction

    task automatic build_memories();
        logic [31:0] lfsr;
        logic [31:0] word;
        int          idx;
        lfsr = SEED;
        // Unlisted sprites sit at y of all ones and never reach a line
        for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
            spr_y[i]    = 16'hffff;
            spr_tile[i] = 0;
            spr_flip[i] = 0;
        end
        for (int r = 0; r < 4; r++) begin
            idx           = sprite_tab[r][0];
            spr_y[idx]    = sprite_tab[r][1];
            spr_tile[idx] = sprite_tab[r][2];
            spr_flip[idx] = sprite_tab[r][3];
        end
        // Sprites 40..50 all cover line 300
        for (int i = 40; i < 51; i++) begin
            spr_y[i]    = 286 + (i - 40);
            spr_tile[i] = i;
            spr_flip[i] = i % 4;
        end
        for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
            i_oam.mem[2*i]   = {2'(spr_flip[i]), 23'd0, 7'(spr_tile[i])};
            i_oam.mem[2*i+1] = {16'(spr_y[i]), 16'd0};
        end
        for (int a = 0; a < 2**`PPU_GFX_AW; a++) begin
            word = '0;
            for (int b = 0; b < `PPU_WORD_W; b++) begin
                lfsr = lfsr_step(lfsr);
                word = {word[30:0], lfsr[0]};
            end
            gfx_img[a]   = word;
            i_gfx.mem[a] = word;
        end
    endtask

    // Reference model of coverage, row flip, bit flip and empty slots
    task automatic compute_expected();
        int          count;
        int          row;
        logic [31:0] w;
        for (int n = 0; n < NUM_LINES; n++) begin
            count = 0;
            for (int s = 0; s < `PPU_SLOTS; s++) begin
                exp_words[n][s] = '0;
            end
            for (int i = 0; i < `PPU_NUM_SPRITES; i++) begin
                if (count < `PPU_SLOTS && line_v[n] >= spr_y[i]
                        && line_v[n] < spr_y[i] + `PPU_SPRITE_HEIGHT) begin
                    row = line_v[n] - spr_y[i];
                    if (spr_flip[i][1]) begin
                        row = `PPU_SPRITE_HEIGHT - 1 - row;
                    end
                    w = gfx_img[spr_tile[i] * `PPU_SPRITE_HEIGHT + row];
                    exp_words[n][count] = spr_flip[i][0] ? reverse_word(w) : w;
                    count++;
                end
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        $display("Run stopped by the watchdog before all lines finished");
        $display("Checks failed");
        $finish;
    end

    initial begin
        int strobes;
        int strobe_at;
        errors = 0;
        reset  = 1'b1;
        vblank = 1'b0;
        hsync  = 1'b0;
        vcount = '0;
        build_memories();
        compute_expected();
        repeat (RESET_CYCLES) @(posedge clk);
        #1 reset = 1'b0;

        // Nothing loads before the first hsync
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            assert (!shift_load_sprite && shift_load_data == '0) else begin
                errors++;
                $display("Load strobe or slot data active after reset with no hsync");
            end
        end

        @(posedge clk);
        #1 vblank = 1'b1;
        repeat (VBLANK_CYCLES) @(posedge clk);
        #1 vblank = 1'b0;

        for (int n = 0; n < NUM_LINES; n++) begin
            repeat (LINE_CYCLES - HSYNC_CYCLES) @(posedge clk);
            #1;
            vcount    = `PPU_VCOUNT_W'(line_v[n]);
            hsync     = 1'b1;
            strobes   = 0;
            strobe_at = 0;
            // c rising edges have passed since hsync went high
            for (int c = 0; c < HSYNC_CYCLES; c++) begin
                @(negedge clk);
                if (shift_load_sprite) begin
                    strobes++;
                    strobe_at = c;
                end
            end
            @(posedge clk);
            #1 hsync = 1'b0;
            assert (strobes == 1 && strobe_at == LOAD_DELAY) else begin
                errors++;
                $display("Line %s saw %0d load strobes, last at cycle %0d, expected one at %0d",
                         line_name[n], strobes, strobe_at, LOAD_DELAY);
            end
            for (int s = 0; s < `PPU_SLOTS; s++) begin
                assert (shift_load_data[s] === exp_words[n][s]) else begin
                    errors++;
                    $display("FAIL %s slot %0d expected %h actual %h",
                             line_name[n], s, exp_words[n][s], shift_load_data[s]);
                end
            end
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
